//--- src.f
+incdir+bench
rtl/simd_fp_pkg.sv
rtl/noncomp_lane_op.sv
rtl/noncomp_lane.sv
rtl/operand_slicer.sv
rtl/result_packer.sv
rtl/simd_noncomp_slice.sv
bench/simd_noncomp_slice_sva.sv
bench/tb_simd_noncomp_slice.sv

//--- bench/slice_tests.svh
`ifndef SLICE_TESTS_SVH
`define SLICE_TESTS_SVH

// ----------------------------------------------------------------------------
// Stimulus helpers enter and leave DRIVE_DELAY after a rising edge
// ----------------------------------------------------------------------------
function automatic slice_req_t make_req(input operation_e op, input logic op_mod,
                                        input sgnj_sub_e sub, input fp_format_e fmt,
                                        input logic vec, input logic [TAG_BITS-1:0] t);
  return '{op: op, op_mod: op_mod, sub_op: sub, fmt: fmt, vectorial: vec, tag: t};
endfunction

function automatic fp_word_u random_word();
  return {$urandom(), $urandom()};
endfunction

// Lane 0 value over random upper bits
function automatic fp_word_u scalar_word(input logic [31:0] v, input bit half);
  fp_word_u w;
  w = random_word();
  if (half) begin
    w.fp16[0] = v[15:0];
  end else begin
    w.fp32[0] = v;
  end
  return w;
endfunction

task automatic drive_inputs(input fp_word_u a, input fp_word_u b, input slice_req_t r,
                            input logic [NUM_LANES-1:0] mask);
  operand_a = a;
  operand_b = b;
  req       = r;
  simd_mask = mask;
  in_valid  = 1'b1;
endtask

task automatic send_item(input fp_word_u a, input fp_word_u b, input slice_req_t r,
                         input logic [NUM_LANES-1:0] mask);
  int waited;
  waited = 0;
  expect_item(a, b, r, mask);
  drive_inputs(a, b, r, mask);
  @(negedge clk);
  while (!in_ready) begin
    waited++;
    if (waited > ITEM_CYCLES) begin
      abort_run("Input stayed stalled, the item was never accepted");
    end
    @(negedge clk);
  end
  @(posedge clk);
  #(DRIVE_DELAY);
  in_valid = 1'b0;
endtask

// Offers one item for a single cycle and withdraws it if refused
task automatic try_send(input fp_word_u a, input fp_word_u b, input slice_req_t r,
                        input logic [NUM_LANES-1:0] mask, output bit taken);
  expect_item(a, b, r, mask);
  drive_inputs(a, b, r, mask);
  @(negedge clk);
  taken = in_ready;
  if (!taken) begin
    exp_result_q.delete(exp_result_q.size() - 1);
    exp_status_q.delete(exp_status_q.size() - 1);
    exp_tag_q.delete(exp_tag_q.size() - 1);
  end
  @(posedge clk);
  #(DRIVE_DELAY);
  in_valid = 1'b0;
endtask

task automatic fill_stalled(input logic [TAG_BITS-1:0] first_tag, output int accepted);
  bit taken;
  taken    = 1'b1;
  accepted = 0;
  while (taken && (accepted <= NumPipeRegs)) begin
    try_send(random_word(), random_word(),
             make_req(MINMAX, accepted[0], J, FP16, 1'b1, first_tag + TAG_BITS'(accepted)),
             '1, taken);
    if (taken) begin
      accepted++;
    end
  end
endtask

task automatic drain_outputs();
  int waited;
  waited = 0;
  while (exp_result_q.size() != 0) begin
    if (waited > ITEM_CYCLES + NumPipeRegs) begin
      abort_run("Expected results did not arrive in time");
    end
    waited++;
    @(posedge clk);
    #(DRIVE_DELAY);
  end
endtask

// ----------------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------------
task automatic reset_and_scalar_minmax();
  fp_word_u a;
  fp_word_u b;
  @(negedge clk);
  check_value("out_valid_o", out_valid, 1'b0);
  check_value("busy_o", busy, 1'b0);
  check_value("in_ready_o", in_ready, 1'b1);
  @(posedge clk);
  #(DRIVE_DELAY);
  a = scalar_word(32'h4049_0fdb, 1'b0);  // pi
  b = scalar_word(32'hc020_0000, 1'b0);  // -2.5
  send_item(a, b, make_req(MINMAX, 1'b0, J, FP32, 1'b0, 4'h1), 4'b0001);
  send_item(a, b, make_req(MINMAX, 1'b1, J, FP32, 1'b0, 4'h2), 4'b0001);
  drain_outputs();
endtask

task automatic fp16_nan_rules();
  send_item(scalar_word(32'h7e00, 1'b1), scalar_word(32'h3c00, 1'b1),  // qNaN vs 1.0
            make_req(MINMAX, 1'b0, J, FP16, 1'b0, 4'h3), 4'b0001);
  send_item(scalar_word(32'h7e10, 1'b1), scalar_word(32'hff00, 1'b1),  // Two quiet NaNs
            make_req(MINMAX, 1'b1, J, FP16, 1'b0, 4'h4), 4'b0001);
  send_item(scalar_word(32'h7c01, 1'b1), scalar_word(32'hc000, 1'b1),  // sNaN vs -2.0
            make_req(MINMAX, 1'b1, J, FP16, 1'b0, 4'h5), 4'b0001);
  send_item(scalar_word(32'h8000, 1'b1), scalar_word(32'h0000, 1'b1),  // -0 vs +0
            make_req(MINMAX, 1'b0, J, FP16, 1'b0, 4'h6), 4'b0001);
  send_item(scalar_word(32'h8000, 1'b1), scalar_word(32'h0000, 1'b1),
            make_req(MINMAX, 1'b1, J, FP16, 1'b0, 4'h7), 4'b0001);
  drain_outputs();
endtask

task automatic vector_sign_injection();
  sgnj_sub_e subs [3];
  subs = '{J, JN, JX};
  foreach (subs[s]) begin
    for (int k = 0; k < 4; k++) begin
      send_item(random_word(), random_word(),
                make_req(SGNJ, 1'b0, subs[s], FP16, 1'b1, TAG_BITS'(4 * s + k)), '1);
    end
  end
  drain_outputs();
endtask

task automatic masked_invalid_flag();
  fp_word_u a;
  fp_word_u b;
  a = {32'h7f80_0001, 32'h3f80_0000};  // sNaN in lane 1, 1.0 in lane 0
  b = {32'h4120_0000, 32'h4000_0000};
  send_item(a, b, make_req(MINMAX, 1'b1, J, FP32, 1'b1, 4'h8), 4'b0011);
  send_item(a, b, make_req(MINMAX, 1'b1, J, FP32, 1'b1, 4'h9), 4'b0001);
  drain_outputs();
endtask

task automatic backpressure_order();
  int accepted;
  check_latency = 1'b0;
  out_ready     = 1'b0;
  fill_stalled(4'h0, accepted);
  check_value("accepted items", accepted, NumPipeRegs);  // One per stage
  @(negedge clk);
  check_value("in_ready_o", in_ready, 1'b0);
  check_value("out_valid_o", out_valid, NumPipeRegs > 0);
  check_value("busy_o", busy, NumPipeRegs > 0);
  @(posedge clk);
  #(DRIVE_DELAY);
  out_ready = 1'b1;
  drain_outputs();
  check_latency = 1'b1;
endtask

task automatic flush_in_flight();
  int accepted;
  out_ready = 1'b0;
  fill_stalled(4'h4, accepted);
  flush = 1'b1;
  @(posedge clk);
  #(DRIVE_DELAY);
  flush = 1'b0;
  @(negedge clk);
  check_value("out_valid_o", out_valid, 1'b0);
  check_value("busy_o", busy, 1'b0);
  @(posedge clk);
  #(DRIVE_DELAY);
  out_ready = 1'b1;
  send_item(random_word(), random_word(), make_req(SGNJ, 1'b0, JX, FP32, 1'b1, 4'hc), '1);
  drain_outputs();
endtask

`endif

//--- bench/tb_simd_noncomp_slice.sv
`timescale 1ns/1ps

module tb_simd_noncomp_slice;
  import simd_fp_pkg::*;

  localparam int unsigned NumPipeRegs   = 2;
  localparam logic        EnableVectors = 1'b1;
  localparam int          CLK_PERIOD    = 40;
  localparam int          DRIVE_DELAY   = 2;   // Inputs change this long after the rising edge
  localparam int          RESET_CYCLES  = 16;
  localparam int          SEED          = 32'h6fc5;
  localparam int          ITEM_CYCLES   = NumPipeRegs + 20;  // Cycle budget per item
  // Scalar FP32, FP16 NaN cases, SGNJ vectors, masked nv, two fills and one item after flush
  localparam int          NUM_ITEMS     = 2 + 5 + 12 + 2 + 2 * (NumPipeRegs + 1) + 1;
  localparam int          RUN_CYCLES    = NUM_ITEMS * ITEM_CYCLES + RESET_CYCLES;

  logic                 clk;
  logic                 arst_n;
  fp_word_u             operand_a;
  fp_word_u             operand_b;
  slice_req_t           req;
  logic [NUM_LANES-1:0] simd_mask;
  logic                 in_valid;
  logic                 in_ready;
  logic                 flush;
  fp_word_u             result;
  status_t              status;
  logic [TAG_BITS-1:0]  tag;
  logic                 out_valid;
  logic                 out_ready;
  logic                 busy;

  // Scoreboard, one entry per item in flight
  fp_word_u            exp_result_q [$];
  status_t             exp_status_q [$];
  logic [TAG_BITS-1:0] exp_tag_q [$];
  int                  accept_cycle_q [$];
  int                  cycle_cnt = 0;
  bit                  check_latency;

  simd_noncomp_slice #(
    .NumPipeRegs   ( NumPipeRegs   ),
    .EnableVectors ( EnableVectors )
  ) dut0 (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .operand_a_i ( operand_a ),
    .operand_b_i ( operand_b ),
    .req_i       ( req       ),
    .simd_mask_i ( simd_mask ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .flush_i     ( flush     ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( tag       ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin : cycle_count
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [WIDTH-1:0] got,
                             input logic [WIDTH-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic bit is_nan(input logic [31:0] v, input bit half);
    if (half) begin
      return (v[14:10] == 5'h1f) && (v[9:0] != 10'h0);
    end
    return (v[30:23] == 8'hff) && (v[22:0] != 23'h0);
  endfunction

  function automatic bit is_snan(input logic [31:0] v, input bit half);
    return is_nan(v, half) && !(half ? v[9] : v[22]);  // Quiet bit clear
  endfunction

  // Monotonic key for sign-magnitude values, -0 lands just below +0
  function automatic logic [32:0] order_key(input logic [31:0] v, input bit half);
    logic sign;
    sign = half ? v[15] : v[31];
    return sign ? {1'b0, ~v} : {1'b1, v};
  endfunction

  function automatic logic [31:0] lane_model(input logic [31:0] a, input logic [31:0] b,
                                             input bit half, input slice_req_t r);
    logic [31:0] sign_bit;
    logic        sa;
    logic        sb;
    logic        s;
    sign_bit = half ? 32'h0000_8000 : 32'h8000_0000;
    if (r.op == SGNJ) begin
      sa = |(a & sign_bit);
      sb = |(b & sign_bit);
      case (r.sub_op)
        JN:      s = ~sb;
        JX:      s = sa ^ sb;
        default: s = sb;
      endcase
      return s ? (a | sign_bit) : (a & ~sign_bit);
    end
    if (is_nan(a, half) && is_nan(b, half)) begin
      return half ? {16'h0, CANON_NAN16} : CANON_NAN32;
    end
    if (is_nan(a, half)) begin
      return b;
    end
    if (is_nan(b, half)) begin
      return a;
    end
    if (r.op_mod) begin
      return (order_key(a, half) > order_key(b, half)) ? a : b;  // Max
    end
    return (order_key(a, half) < order_key(b, half)) ? a : b;
  endfunction

  task automatic expect_item(input fp_word_u a, input fp_word_u b, input slice_req_t r,
                             input logic [NUM_LANES-1:0] mask);
    fp_word_u    res;
    status_t     st;
    bit          half;
    int          lanes;
    logic [31:0] la;
    logic [31:0] lb;
    logic [31:0] lr;
    half  = (r.fmt == FP16);
    lanes = 1;
    if (r.vectorial && EnableVectors) begin
      lanes = half ? 4 : 2;  // FP32 only fits lanes 0 and 1
    end
    res = '1;  // Slots without a result stay NaN-boxed
    st  = '0;
    for (int l = 0; l < lanes; l++) begin
      la = half ? {16'h0, a.fp16[l]} : a.fp32[l];
      lb = half ? {16'h0, b.fp16[l]} : b.fp32[l];
      lr = lane_model(la, lb, half, r);
      if (half) begin
        res.fp16[l] = lr[15:0];
      end else begin
        res.fp32[l] = lr;
      end
      if (mask[l] && (r.op == MINMAX) && (is_snan(la, half) || is_snan(lb, half))) begin
        st.nv = 1'b1;
      end
    end
    exp_result_q.push_back(res);
    exp_status_q.push_back(st);
    exp_tag_q.push_back(r.tag);
  endtask

  // --------------------------------------------------------------------------
  // Output monitor, samples mid-cycle
  // --------------------------------------------------------------------------
  task automatic check_output();
    if (exp_result_q.size() == 0) begin
      abort_run("A result was delivered with no item outstanding");
    end else begin
      check_value("result_o", result, exp_result_q.pop_front());
      check_value("status_o", status, exp_status_q.pop_front());
      check_value("tag_o", tag, exp_tag_q.pop_front());
      if (check_latency) begin
        check_value("latency", cycle_cnt - accept_cycle_q[0], NumPipeRegs);
      end
      accept_cycle_q.delete(0);
    end
  endtask

  always @(negedge clk) begin : monitor
    if (arst_n) begin
      if (in_valid && in_ready) begin
        accept_cycle_q.push_back(cycle_cnt);
      end
      if (out_valid && out_ready) begin
        check_output();
      end
      if (flush) begin  // Everything in flight is dropped
        exp_result_q.delete();
        exp_status_q.delete();
        exp_tag_q.delete();
        accept_cycle_q.delete();
      end
    end
  end

  initial begin : watchdog
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Timeout, tests still running after %0d cycles", RUN_CYCLES);
    $display("** FAIL **");
    $fatal(1, "Watchdog expired");
  end

  `include "slice_tests.svh"

  initial begin : main
    int pending;
    void'($urandom(SEED));
    operand_a     = '0;
    operand_b     = '0;
    req           = '0;
    simd_mask     = '0;
    in_valid      = 1'b0;
    flush         = 1'b0;
    out_ready     = 1'b1;
    arst_n        = 1'b0;
    check_latency = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    arst_n = 1'b1;

    reset_and_scalar_minmax();
    fp16_nan_rules();
    vector_sign_injection();
    masked_invalid_flag();
    backpressure_order();
    flush_in_flight();

    pending = exp_result_q.size();
    if (pending == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("%0d expected results were never delivered", pending);
      $display("** FAIL **");
      $fatal(1, "Run ended with outstanding items");
    end
  end

endmodule

//--- bench/simd_noncomp_slice_sva.sv
`timescale 1ns/1ps

module simd_noncomp_slice_sva (
  input logic                             clk_i,
  input logic                             arst_n_i,
  input logic                             flush_i,
  input logic                             out_valid_o,
  input logic                             out_ready_i,
  input simd_fp_pkg::fp_word_u            result_o,
  input logic [simd_fp_pkg::TAG_BITS-1:0] tag_o
);

  // Nothing leaves while the slice is held in reset
  reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_o)
    else $error("out_valid_o high during reset");

  // A refused result waits unchanged
  stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=>
      (out_valid_o && $stable(result_o) && $stable(tag_o)))
    else $error("Stalled output changed before it was taken");

  flush_clears: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !out_valid_o)
    else $error("out_valid_o high in the cycle after flush_i");

endmodule

bind simd_noncomp_slice simd_noncomp_slice_sva sva0 (.*);

//--- rtl/simd_noncomp_slice.sv
`timescale 1ns/1ps

module simd_noncomp_slice #(
  parameter int unsigned NumPipeRegs   = 2,
  parameter logic        EnableVectors = 1'b1
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  simd_fp_pkg::fp_word_u             operand_a_i,
  input  simd_fp_pkg::fp_word_u             operand_b_i,
  input  simd_fp_pkg::slice_req_t           req_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0] simd_mask_i,
  // Input handshake
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  input  logic                              flush_i,
  // Output side
  output simd_fp_pkg::fp_word_u             result_o,
  output simd_fp_pkg::status_t              status_o,
  output logic [simd_fp_pkg::TAG_BITS-1:0]  tag_o,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic                              busy_o
);
  import simd_fp_pkg::*;

  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] lane_a;
  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] lane_b;
  logic [NUM_LANES-1:0]                 lane_in_valid;
  logic [NUM_LANES-1:0]                 lane_in_ready;   // Lane 0 drives upstream
  lane_aux_t                            in_aux;
  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] lane_result;
  status_t [NUM_LANES-1:0]              lane_status;
  logic [NUM_LANES-1:0]                 lane_mask;
  lane_aux_t [NUM_LANES-1:0]            lane_aux;        // Lane 0 copy is used
  logic [NUM_LANES-1:0][TAG_BITS-1:0]   lane_tag;
  logic [NUM_LANES-1:0]                 lane_out_valid;
  logic [NUM_LANES-1:0]                 lane_out_ready;
  logic [NUM_LANES-1:0]                 lane_busy;

  operand_slicer #(
    .EnableVectors ( EnableVectors )
  ) i_slicer (
    .operand_a_i,
    .operand_b_i,
    .req_i,
    .in_valid_i,
    .lane_a_o     ( lane_a        ),
    .lane_b_o     ( lane_b        ),
    .lane_valid_o ( lane_in_valid ),
    .aux_o        ( in_aux        )
  );

  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
    noncomp_lane #(
      .NumPipeRegs ( NumPipeRegs                ),
      .HasFp32     ( l < WIDTH/LANE_WIDTH       )  // Lanes 0 and 1
    ) i_lane (
      .clk_i,
      .arst_n_i,
      .a_i         ( lane_a[l]         ),
      .b_i         ( lane_b[l]         ),
      .req_i,
      .aux_i       ( in_aux            ),
      .mask_i      ( simd_mask_i[l]    ),
      .in_valid_i  ( lane_in_valid[l]  ),
      .in_ready_o  ( lane_in_ready[l]  ),
      .flush_i,
      .result_o    ( lane_result[l]    ),
      .status_o    ( lane_status[l]    ),
      .mask_o      ( lane_mask[l]      ),
      .aux_o       ( lane_aux[l]       ),
      .tag_o       ( lane_tag[l]       ),
      .out_valid_o ( lane_out_valid[l] ),
      .out_ready_i ( lane_out_ready[l] ),
      .busy_o      ( lane_busy[l]      )
    );
  end

  result_packer i_packer (
    .lane_result_i ( lane_result    ),
    .lane_status_i ( lane_status    ),
    .lane_mask_i   ( lane_mask      ),
    .lane_valid_i  ( lane_out_valid ),
    .aux_i         ( lane_aux[0]    ),
    .out_ready_i,
    .lane_ready_o  ( lane_out_ready ),
    .result_o,
    .status_o,
    .out_valid_o
  );

  assign in_ready_o = lane_in_ready[0];
  assign tag_o      = lane_tag[0];
  assign busy_o     = |lane_busy;

endmodule

//--- rtl/result_packer.sv
`timescale 1ns/1ps

module result_packer (
  input  logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::LANE_WIDTH-1:0] lane_result_i,
  input  simd_fp_pkg::status_t [simd_fp_pkg::NUM_LANES-1:0] lane_status_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0] lane_mask_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0] lane_valid_i,
  input  simd_fp_pkg::lane_aux_t            aux_i,       // From lane 0
  input  logic                              out_ready_i,
  output logic [simd_fp_pkg::NUM_LANES-1:0] lane_ready_o,
  output simd_fp_pkg::fp_word_u             result_o,
  output simd_fp_pkg::status_t              status_o,
  output logic                              out_valid_o
);
  import simd_fp_pkg::*;

  logic [NUM_LANES-1:0] lane_used;  // Lane contributes to this result

  // --------------------------------------------------------------------------
  // Handshake gating
  // --------------------------------------------------------------------------
  always_comb begin : lane_gating
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_used[l]    = lane_valid_i[l] & ((l == 0) | aux_i.vectorial);
      lane_ready_o[l] = out_ready_i & ((l == 0) | aux_i.vectorial);
    end
  end

  assign out_valid_o = lane_valid_i[0];  // Lanes move in lockstep

  // --------------------------------------------------------------------------
  // Packing
  // --------------------------------------------------------------------------
  always_comb begin : pack
    result_o = '1;  // NaN-box empty slots and upper bits
    if (aux_i.fmt == FP16) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (lane_used[l]) begin
          result_o.fp16[l] = lane_result_i[l][15:0];
        end
      end
    end else begin
      for (int l = 0; l < int'(WIDTH/LANE_WIDTH); l++) begin
        if (lane_used[l]) begin
          result_o.fp32[l] = lane_result_i[l];
        end
      end
    end
  end

  // Only flags of lanes enabled by the SIMD mask count
  always_comb begin : collapse_status
    status_o = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (lane_used[l] && lane_mask_i[l]) begin
        status_o |= lane_status_i[l];
      end
    end
  end

endmodule

//--- rtl/operand_slicer.sv
`timescale 1ns/1ps

module operand_slicer #(
  parameter logic EnableVectors = 1'b1
) (
  input  simd_fp_pkg::fp_word_u   operand_a_i,
  input  simd_fp_pkg::fp_word_u   operand_b_i,
  input  simd_fp_pkg::slice_req_t req_i,
  input  logic                    in_valid_i,
  output logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::LANE_WIDTH-1:0] lane_a_o,
  output logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::LANE_WIDTH-1:0] lane_b_o,
  output logic [simd_fp_pkg::NUM_LANES-1:0] lane_valid_o,
  output simd_fp_pkg::lane_aux_t            aux_o
);
  import simd_fp_pkg::*;

  logic vectorial;

  assign vectorial = req_i.vectorial & EnableVectors;  // Scalar only when vectors are off
  assign aux_o     = '{fmt: req_i.fmt, vectorial: vectorial};

  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
    localparam bit HAS_FP32 = (l < WIDTH/LANE_WIDTH);
    logic fmt_ok;  // Lane holds a value of the requested format

    if (HAS_FP32) begin : gen_fp32
      assign lane_a_o[l] = (req_i.fmt == FP16) ?
                           {{(LANE_WIDTH-16){1'b0}}, operand_a_i.fp16[l]} :
                           operand_a_i.fp32[l];
      assign lane_b_o[l] = (req_i.fmt == FP16) ?
                           {{(LANE_WIDTH-16){1'b0}}, operand_b_i.fp16[l]} :
                           operand_b_i.fp32[l];
      assign fmt_ok      = 1'b1;
    end else begin : gen_fp16
      assign lane_a_o[l] = {{(LANE_WIDTH-16){1'b0}}, operand_a_i.fp16[l]};
      assign lane_b_o[l] = {{(LANE_WIDTH-16){1'b0}}, operand_b_i.fp16[l]};
      assign fmt_ok      = (req_i.fmt == FP16);
    end

    // Upper lanes only take part in vector operations
    assign lane_valid_o[l] = in_valid_i & ((l == 0) | vectorial) & fmt_ok;
  end

endmodule

//--- rtl/noncomp_lane.sv
`timescale 1ns/1ps

module noncomp_lane #(
  parameter int unsigned NumPipeRegs = 2,
  parameter logic        HasFp32     = 1'b1
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic [simd_fp_pkg::LANE_WIDTH-1:0] a_i,
  input  logic [simd_fp_pkg::LANE_WIDTH-1:0] b_i,
  input  simd_fp_pkg::slice_req_t            req_i,
  input  simd_fp_pkg::lane_aux_t             aux_i,
  input  logic                               mask_i,
  input  logic                               in_valid_i,
  output logic                               in_ready_o,
  input  logic                               flush_i,
  output logic [simd_fp_pkg::LANE_WIDTH-1:0] result_o,
  output simd_fp_pkg::status_t               status_o,
  output logic                               mask_o,
  output simd_fp_pkg::lane_aux_t             aux_o,
  output logic [simd_fp_pkg::TAG_BITS-1:0]   tag_o,
  output logic                               out_valid_o,
  input  logic                               out_ready_i,
  output logic                               busy_o
);
  import simd_fp_pkg::*;

  typedef struct packed {
    logic [LANE_WIDTH-1:0] result;
    status_t               status;
    logic                  mask;
    lane_aux_t             aux;
    logic [TAG_BITS-1:0]   tag;
  } stage_t;

  logic [LANE_WIDTH-1:0] op_result;
  status_t               op_status;

  // Index i holds the item after i register stages
  stage_t pipe_q  [NumPipeRegs+1];
  logic   valid_q [NumPipeRegs+1];
  logic   ready   [NumPipeRegs+1];  // Combinational, travels backwards

  noncomp_lane_op #(
    .HasFp32 ( HasFp32 )
  ) i_lane_op (
    .a_i,
    .b_i,
    .fmt_i    ( req_i.fmt    ),
    .op_i     ( req_i.op     ),
    .op_mod_i ( req_i.op_mod ),
    .sub_op_i ( req_i.sub_op ),
    .result_o ( op_result    ),
    .status_o ( op_status    )
  );

  assign pipe_q[0]  = '{result: op_result, status: op_status, mask: mask_i,
                        aux: aux_i, tag: req_i.tag};
  assign valid_q[0] = in_valid_i;

  // --------------------------------------------------------------------------
  // Register stages
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic reg_ena;

    // Advance when the next stage takes the item or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign reg_ena  = ready[i] & valid_q[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;  // Drop everything in flight
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        pipe_q[i+1] <= pipe_q[i];
      end
    end
  end

  assign ready[NumPipeRegs] = out_ready_i;
  assign in_ready_o         = ready[0];
  assign out_valid_o        = valid_q[NumPipeRegs];

  assign result_o = pipe_q[NumPipeRegs].result;
  assign status_o = pipe_q[NumPipeRegs].status;
  assign mask_o   = pipe_q[NumPipeRegs].mask;
  assign aux_o    = pipe_q[NumPipeRegs].aux;
  assign tag_o    = pipe_q[NumPipeRegs].tag;

  always_comb begin : busy
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumPipeRegs); i++) begin
      busy_o |= valid_q[i];
    end
  end

endmodule

//--- rtl/noncomp_lane_op.sv
`timescale 1ns/1ps

module noncomp_lane_op #(
  parameter logic HasFp32 = 1'b1
) (
  input  logic [simd_fp_pkg::LANE_WIDTH-1:0] a_i,
  input  logic [simd_fp_pkg::LANE_WIDTH-1:0] b_i,
  input  simd_fp_pkg::fp_format_e            fmt_i,
  input  simd_fp_pkg::operation_e            op_i,
  input  logic                               op_mod_i,  // Max when set
  input  simd_fp_pkg::sgnj_sub_e             sub_op_i,
  output logic [simd_fp_pkg::LANE_WIDTH-1:0] result_o,
  output simd_fp_pkg::status_t               status_o
);
  import simd_fp_pkg::*;

  typedef struct packed {
    logic        sign;
    logic [30:0] mag;   // Exponent and mantissa, FP16 zero-extended
    logic        nan;
    logic        snan;
  } fp_info_t;

  // Split a lane value into sign, magnitude and NaN class
  function automatic fp_info_t classify(input logic [LANE_WIDTH-1:0] v,
                                        input fp_format_e fmt);
    fp_info_t info;
    if (HasFp32 && (fmt == FP32)) begin
      info.sign = v[31];
      info.mag  = v[30:0];
      info.nan  = (v[30:23] == 8'hff) && (v[22:0] != '0);
      info.snan = info.nan && !v[22];  // Quiet bit clear
    end else begin
      info.sign = v[15];
      info.mag  = {16'b0, v[14:0]};
      info.nan  = (v[14:10] == 5'h1f) && (v[9:0] != '0);
      info.snan = info.nan && !v[9];
    end
    return info;
  endfunction

  fp_info_t              a_info;
  fp_info_t              b_info;
  logic                  is_fp32;
  logic                  a_less;
  logic                  pick_a;
  logic                  new_sign;
  logic [LANE_WIDTH-1:0] canon_nan;
  logic [LANE_WIDTH-1:0] minmax_res;
  logic [LANE_WIDTH-1:0] sgnj_res;

  assign is_fp32   = HasFp32 && (fmt_i == FP32);  // Constant low without FP32 support
  assign a_info    = classify(a_i, fmt_i);
  assign b_info    = classify(b_i, fmt_i);
  assign canon_nan = is_fp32 ? CANON_NAN32 : {{(LANE_WIDTH-16){1'b0}}, CANON_NAN16};

  // Sign-magnitude ordering, -0 sorts below +0
  always_comb begin : compare
    if (a_info.sign != b_info.sign) begin
      a_less = a_info.sign;
    end else if (a_info.sign) begin
      a_less = a_info.mag > b_info.mag;  // Both negative, larger magnitude is smaller
    end else begin
      a_less = a_info.mag < b_info.mag;
    end
  end

  always_comb begin : minmax
    pick_a = op_mod_i ? ~a_less : a_less;
    if (a_info.nan && b_info.nan) begin
      minmax_res = canon_nan;
    end else if (a_info.nan) begin
      minmax_res = b_i;
    end else if (b_info.nan) begin
      minmax_res = a_i;
    end else begin
      minmax_res = pick_a ? a_i : b_i;
    end
  end

  always_comb begin : sign_inject
    case (sub_op_i)
      JN:      new_sign = ~b_info.sign;
      JX:      new_sign = a_info.sign ^ b_info.sign;
      default: new_sign = b_info.sign;
    endcase
    sgnj_res = a_i;
    if (is_fp32) begin
      sgnj_res[31] = new_sign;
    end else begin
      sgnj_res[15] = new_sign;
    end
  end

  always_comb begin : select_out
    result_o = (op_i == SGNJ) ? sgnj_res : minmax_res;
    if (!is_fp32) begin
      result_o[LANE_WIDTH-1:16] = '0;  // FP16 zero-extended
    end
    status_o    = '0;
    status_o.nv = (op_i == MINMAX) && (a_info.snan || b_info.snan);
  end

endmodule

//--- rtl/simd_fp_pkg.sv
package simd_fp_pkg;

  // --------------------------------------------------------------------------
  // Slice geometry
  // --------------------------------------------------------------------------
  localparam int unsigned WIDTH      = 64;  // Operand and result word
  localparam int unsigned NUM_LANES  = 4;   // One lane per FP16 value
  localparam int unsigned LANE_WIDTH = 32;  // Widest format held by a lane
  localparam int unsigned TAG_BITS   = 4;

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic {
    MINMAX = 1'b0,
    SGNJ   = 1'b1
  } operation_e;

  // Sign injection variants
  typedef enum logic [1:0] {
    J  = 2'b00,  // Sign of b
    JN = 2'b01,  // Inverted sign of b
    JX = 2'b10   // Sign of a xor sign of b
  } sgnj_sub_e;

  // IEEE exception flags, same order as fflags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Control that travels with an operation
  typedef struct packed {
    operation_e          op;
    logic                op_mod;     // Max when set
    sgnj_sub_e           sub_op;
    fp_format_e          fmt;
    logic                vectorial;
    logic [TAG_BITS-1:0] tag;
  } slice_req_t;

  // Side data carried by lane 0 for result packing
  typedef struct packed {
    fp_format_e fmt;
    logic       vectorial;  // Already gated by EnableVectors
  } lane_aux_t;

  // One word, seen as FP32 or FP16 lanes, lane 0 in the low bits
  typedef union packed {
    logic [WIDTH/32-1:0][31:0] fp32;
    logic [WIDTH/16-1:0][15:0] fp16;
  } fp_word_u;

  // Canonical quiet NaNs
  localparam logic [31:0] CANON_NAN32 = 32'h7fc0_0000;
  localparam logic [15:0] CANON_NAN16 = 16'h7e00;

endpackage
